// ==== hdl/l1_cache_pkg.sv ====
package l1_cache_pkg;

    // Core side widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;
    localparam int STRB_W = DATA_W / 8;
    localparam int OFFSET_W = 3;

    // Two ways, 16 sets each, four double words per line
    localparam int WAYS = 2;
    localparam int SETS = 16;
    localparam int SET_W = 4;
    localparam int BEATS = 4;
    localparam int BEAT_W = 2;
    localparam int TAG_W = ADDR_W - OFFSET_W - SET_W - BEAT_W;
    localparam int META_W = TAG_W + 3;
    localparam int LINE_ADDR_W = SET_W + BEAT_W;

    // Last index of the clear walk and of a burst
    localparam logic [SET_W-1:0] LAST_SET = SET_W'(SETS - 1);
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(BEATS - 1);

    // Status bits sit directly above the tag
    localparam int META_DIRTY = TAG_W;
    localparam int META_VALID = TAG_W + 1;
    localparam int META_LRU = TAG_W + 2;

    typedef enum logic [2:0] {
        ST_RESET,
        ST_PREPARE,
        ST_READY,
        ST_FLUSH,
        ST_FLUSH_ACK,
        ST_LOAD,
        ST_WAY_WB,
        ST_RETRY
    } cache_state_e;

    // Source of the word written into the metadata and data RAMs
    typedef enum logic [1:0] {
        WB_CORE,
        WB_MEM,
        WB_CLEAR
    } wb_src_e;

endpackage

// ==== hdl/cache_ram.sv ====
module cache_ram #(
    parameter int DEPTH_W = 4,
    parameter int WIDTH = 32
) (
    input  logic               clk,
    input  logic [DEPTH_W-1:0] raddr,
    output logic [WIDTH-1:0]   rd,
    input  logic [DEPTH_W-1:0] waddr,
    input  logic               we,
    input  logic [WIDTH-1:0]   wr
);

    logic [WIDTH-1:0] mem [2**DEPTH_W];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wr;
        end
        // Same-address write goes straight to the read port
        // so a back-to-back request sees the updated word
        if (we && (waddr == raddr)) begin
            rd <= wr;
        end else begin
            rd <= mem[raddr];
        end
    end

endmodule

// ==== hdl/cache_tag_check.sv ====
module cache_tag_check (
    input  logic [l1_cache_pkg::TAG_W-1:0]  req_tag,
    input  logic                            req_wen,
    input  logic                            req_valid,
    input  logic [l1_cache_pkg::META_W-1:0] meta_rd0,
    input  logic [l1_cache_pkg::META_W-1:0] meta_rd1,
    output logic                            hit,
    output logic                            hit_way,
    output logic                            victim,
    output logic                            victim_dirty,
    output logic [l1_cache_pkg::TAG_W-1:0]  victim_tag,
    output logic [l1_cache_pkg::META_W-1:0] meta_core0,
    output logic [l1_cache_pkg::META_W-1:0] meta_core1,
    output logic [l1_cache_pkg::META_W-1:0] meta_mem0,
    output logic [l1_cache_pkg::META_W-1:0] meta_mem1
);

    logic [l1_cache_pkg::META_W-1:0] meta_rd [l1_cache_pkg::WAYS];
    logic [l1_cache_pkg::META_W-1:0] meta_core [l1_cache_pkg::WAYS];
    logic [l1_cache_pkg::META_W-1:0] meta_mem [l1_cache_pkg::WAYS];
    logic [l1_cache_pkg::WAYS-1:0]   way_match;
    logic [l1_cache_pkg::WAYS-1:0]   new_lru;
    logic                            way0_newer;

    assign meta_rd[0] = meta_rd0;
    assign meta_rd[1] = meta_rd1;

    // LRU encoding across both ways
    // Equal bits mean way 0 is newer, different bits mean way 1 is newer
    assign way0_newer = meta_rd[0][l1_cache_pkg::META_LRU] ==
                        meta_rd[1][l1_cache_pkg::META_LRU];
    // Way 0 becomes newest by copying way 1's bit
    assign new_lru[0] = meta_rd[1][l1_cache_pkg::META_LRU];
    // Way 1 becomes newest by taking the inverse of way 0's bit
    assign new_lru[1] = !meta_rd[0][l1_cache_pkg::META_LRU];

    for (genvar w = 0; w < l1_cache_pkg::WAYS; w++) begin : g_way
        assign way_match[w] = meta_rd[w][l1_cache_pkg::META_VALID] &&
                              (meta_rd[w][l1_cache_pkg::TAG_W-1:0] == req_tag);

        // Hit update keeps the tag, a write marks the line dirty
        assign meta_core[w] = {new_lru[w], 1'b1,
                               req_wen | meta_rd[w][l1_cache_pkg::META_DIRTY],
                               meta_rd[w][l1_cache_pkg::TAG_W-1:0]};

        // Refilled line is clean and owned by the requested tag
        assign meta_mem[w] = {new_lru[w], 1'b1, 1'b0, req_tag};
    end

    assign hit = req_valid && (|way_match);
    assign hit_way = way_match[1];

    // Older way is replaced
    assign victim = way0_newer;
    assign victim_dirty = meta_rd[victim][l1_cache_pkg::META_VALID] &&
                          meta_rd[victim][l1_cache_pkg::META_DIRTY];
    assign victim_tag = meta_rd[victim][l1_cache_pkg::TAG_W-1:0];

    assign meta_core0 = meta_core[0];
    assign meta_core1 = meta_core[1];
    assign meta_mem0 = meta_mem[0];
    assign meta_mem1 = meta_mem[1];

endmodule

// ==== hdl/cache_miss_ctrl.sv ====
module cache_miss_ctrl (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             req_valid,
    input  logic                             hit,
    input  logic                             victim,
    input  logic                             victim_dirty,
    input  logic [l1_cache_pkg::BEAT_W-1:0]  req_beat,
    input  logic                             mem_req_ready,
    input  logic                             mem_resp_valid,
    output logic                             int_ready,
    output l1_cache_pkg::wb_src_e            wb_src,
    output logic [l1_cache_pkg::WAYS-1:0]    meta_we,
    output logic [l1_cache_pkg::WAYS-1:0]    data_we,
    output logic                             reload_en,
    output logic [l1_cache_pkg::BEAT_W-1:0]  reload_beat,
    output logic                             clear_en,
    output logic [l1_cache_pkg::SET_W-1:0]   clear_set,
    output logic                             flush_sel,
    output logic                             mem_req_wen,
    output logic                             mem_req_valid,
    output logic                             mem_resp_ready
);

    l1_cache_pkg::cache_state_e      state;
    logic [l1_cache_pkg::BEAT_W-1:0] beat_cnt;
    logic [l1_cache_pkg::WAYS-1:0]   data_we_q;
    logic                            miss;
    logic                            load_start;
    logic                            flush_take;
    logic                            resp_take;

    assign miss = req_valid && !hit;

    // Core side only runs while idle with no miss in the compare stage
    assign int_ready = ((state == l1_cache_pkg::ST_PREPARE) ||
                        (state == l1_cache_pkg::ST_READY)) && !miss;

    // Line walk owns the data RAM address from the miss until the retry
    assign reload_en = !int_ready && (state != l1_cache_pkg::ST_RETRY) &&
                       (state != l1_cache_pkg::ST_RESET);
    assign clear_en = (state == l1_cache_pkg::ST_RESET);

    assign flush_take = (state == l1_cache_pkg::ST_FLUSH) &&
                        mem_req_valid && mem_req_ready;
    assign resp_take = mem_resp_valid && mem_resp_ready;

    // Registered RAM read, so fetch the next flush beat as soon as this one is taken
    assign reload_beat = flush_take ? beat_cnt + 1'b1 : beat_cnt;

    // Refill writes land only on beats the memory returned
    assign data_we = data_we_q & {l1_cache_pkg::WAYS{resp_take}};

    // Read burst starts on a clean miss or once the flush is acknowledged
    assign load_start = ((state == l1_cache_pkg::ST_READY) && miss && !victim_dirty) ||
                        ((state == l1_cache_pkg::ST_FLUSH_ACK) && resp_take);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= l1_cache_pkg::ST_RESET;
            clear_set <= l1_cache_pkg::LAST_SET;
            // Invalidate walk writes every set right away
            meta_we <= '1;
            data_we_q <= '0;
            wb_src <= l1_cache_pkg::WB_CLEAR;
            beat_cnt <= '0;
            flush_sel <= 1'b0;
            mem_req_wen <= 1'b0;
            mem_req_valid <= 1'b0;
            mem_resp_ready <= 1'b0;
        end else begin
            case (state)
                l1_cache_pkg::ST_RESET: begin
                    clear_set <= clear_set - 1'b1;
                    if (clear_set == '0) begin
                        meta_we <= '0;
                        wb_src <= l1_cache_pkg::WB_CORE;
                        state <= l1_cache_pkg::ST_PREPARE;
                    end
                end
                l1_cache_pkg::ST_PREPARE: begin
                    state <= l1_cache_pkg::ST_READY;
                end
                l1_cache_pkg::ST_READY: begin
                    // Dirty victim goes out first
                    if (miss && victim_dirty) begin
                        beat_cnt <= '0;
                        flush_sel <= 1'b1;
                        mem_req_wen <= 1'b1;
                        state <= l1_cache_pkg::ST_FLUSH;
                    end
                end
                l1_cache_pkg::ST_FLUSH: begin
                    // First cycle only primes the data RAM read
                    if (!mem_req_valid) begin
                        mem_req_valid <= 1'b1;
                    end else if (mem_req_ready) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (beat_cnt == l1_cache_pkg::LAST_BEAT) begin
                            mem_req_valid <= 1'b0;
                            mem_resp_ready <= 1'b1;
                            state <= l1_cache_pkg::ST_FLUSH_ACK;
                        end
                    end
                end
                l1_cache_pkg::ST_FLUSH_ACK: begin
                    // Left through load_start below
                end
                l1_cache_pkg::ST_LOAD: begin
                    // Single request beat
                    if (mem_req_ready) begin
                        mem_req_valid <= 1'b0;
                    end
                    if (resp_take) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (beat_cnt == l1_cache_pkg::LAST_BEAT) begin
                            mem_resp_ready <= 1'b0;
                            meta_we[victim] <= 1'b1;
                            data_we_q <= '0;
                            // Point the data RAM at the replayed word
                            beat_cnt <= req_beat;
                            state <= l1_cache_pkg::ST_WAY_WB;
                        end
                    end
                end
                l1_cache_pkg::ST_WAY_WB: begin
                    meta_we <= '0;
                    wb_src <= l1_cache_pkg::WB_CORE;
                    state <= l1_cache_pkg::ST_RETRY;
                end
                l1_cache_pkg::ST_RETRY: begin
                    // RAMs read the held request this cycle
                    state <= l1_cache_pkg::ST_READY;
                end
            endcase

            if (load_start) begin
                beat_cnt <= '0;
                flush_sel <= 1'b0;
                mem_req_wen <= 1'b0;
                mem_req_valid <= 1'b1;
                mem_resp_ready <= 1'b1;
                wb_src <= l1_cache_pkg::WB_MEM;
                data_we_q[victim] <= 1'b1;
                state <= l1_cache_pkg::ST_LOAD;
            end
        end
    end

endmodule

// ==== hdl/l1_cache.sv ====
module l1_cache (
    input  logic                            clk,
    input  logic                            rst,
    // Core port
    input  logic [l1_cache_pkg::ADDR_W-1:0] core_req_addr,
    input  logic                            core_req_wen,
    input  logic [l1_cache_pkg::DATA_W-1:0] core_req_wdata,
    input  logic [l1_cache_pkg::STRB_W-1:0] core_req_wmask,
    input  logic                            core_req_valid,
    output logic                            core_req_ready,
    output logic                            core_resp_valid,
    output logic [l1_cache_pkg::DATA_W-1:0] core_resp_rdata,
    // Burst memory port
    output logic [l1_cache_pkg::ADDR_W-1:0] mem_req_addr,
    output logic                            mem_req_wen,
    output logic [l1_cache_pkg::DATA_W-1:0] mem_req_wdata,
    output logic                            mem_req_valid,
    input  logic                            mem_req_ready,
    input  logic [l1_cache_pkg::DATA_W-1:0] mem_resp_rdata,
    input  logic                            mem_resp_valid,
    output logic                            mem_resp_ready
);

    // Compare stage request
    logic [l1_cache_pkg::ADDR_W-1:0]      req_addr;
    logic                                 req_wen;
    logic [l1_cache_pkg::DATA_W-1:0]      req_wdata;
    logic [l1_cache_pkg::STRB_W-1:0]      req_wmask;
    logic                                 req_valid;

    logic [l1_cache_pkg::TAG_W-1:0]       req_tag;
    logic [l1_cache_pkg::SET_W-1:0]       req_set;
    logic [l1_cache_pkg::BEAT_W-1:0]      req_beat;
    logic [l1_cache_pkg::LINE_ADDR_W-1:0] req_line;
    logic [l1_cache_pkg::LINE_ADDR_W-1:0] core_line;

    logic [l1_cache_pkg::SET_W-1:0]       meta_raddr;
    logic [l1_cache_pkg::SET_W-1:0]       meta_waddr;
    logic [l1_cache_pkg::LINE_ADDR_W-1:0] data_raddr;
    logic [l1_cache_pkg::LINE_ADDR_W-1:0] data_waddr;
    logic [l1_cache_pkg::LINE_ADDR_W-1:0] reload_line;

    logic [l1_cache_pkg::META_W-1:0]      meta_rd [l1_cache_pkg::WAYS];
    logic [l1_cache_pkg::META_W-1:0]      meta_wr [l1_cache_pkg::WAYS];
    logic [l1_cache_pkg::META_W-1:0]      meta_core [l1_cache_pkg::WAYS];
    logic [l1_cache_pkg::META_W-1:0]      meta_mem [l1_cache_pkg::WAYS];
    logic [l1_cache_pkg::DATA_W-1:0]      data_rd [l1_cache_pkg::WAYS];
    logic [l1_cache_pkg::DATA_W-1:0]      data_wr [l1_cache_pkg::WAYS];
    logic [l1_cache_pkg::WAYS-1:0]        meta_we_mux;
    logic [l1_cache_pkg::WAYS-1:0]        data_we_mux;

    logic                                 hit;
    logic                                 hit_way;
    logic                                 victim;
    logic                                 victim_dirty;
    logic [l1_cache_pkg::TAG_W-1:0]       victim_tag;

    logic                                 int_ready;
    l1_cache_pkg::wb_src_e                wb_src;
    logic [l1_cache_pkg::WAYS-1:0]        meta_we;
    logic [l1_cache_pkg::WAYS-1:0]        data_we;
    logic                                 reload_en;
    logic [l1_cache_pkg::BEAT_W-1:0]      reload_beat;
    logic                                 clear_en;
    logic [l1_cache_pkg::SET_W-1:0]       clear_set;
    logic                                 flush_sel;

    // Request advances only while the cache accepts new work
    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid <= 1'b0;
        end else if (int_ready) begin
            req_valid <= core_req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (int_ready) begin
            req_addr <= core_req_addr;
            req_wen <= core_req_wen;
            req_wdata <= core_req_wdata;
            req_wmask <= core_req_wmask;
        end
    end

    // Tag, set, beat, byte offset from the top down
    assign req_tag = req_addr[l1_cache_pkg::ADDR_W-1 -: l1_cache_pkg::TAG_W];
    assign req_line = req_addr[l1_cache_pkg::OFFSET_W +: l1_cache_pkg::LINE_ADDR_W];
    assign req_set = req_line[l1_cache_pkg::BEAT_W +: l1_cache_pkg::SET_W];
    assign req_beat = req_line[l1_cache_pkg::BEAT_W-1:0];
    assign core_line = core_req_addr[l1_cache_pkg::OFFSET_W +: l1_cache_pkg::LINE_ADDR_W];
    assign reload_line = {req_set, reload_beat};

    // Hold the compare-stage address while stalled
    assign meta_raddr = int_ready ? core_line[l1_cache_pkg::BEAT_W +: l1_cache_pkg::SET_W]
                                  : req_set;
    assign data_raddr = reload_en ? reload_line : (int_ready ? core_line : req_line);
    assign meta_waddr = clear_en ? clear_set : req_set;
    assign data_waddr = reload_en ? reload_line : req_line;

    for (genvar w = 0; w < l1_cache_pkg::WAYS; w++) begin : g_way
        logic                            way_hit;
        logic [l1_cache_pkg::DATA_W-1:0] merged;

        cache_ram #(
            .DEPTH_W(l1_cache_pkg::SET_W),
            .WIDTH(l1_cache_pkg::META_W)
        ) u_meta_ram (
            .clk(clk),
            .raddr(meta_raddr),
            .rd(meta_rd[w]),
            .waddr(meta_waddr),
            .we(meta_we_mux[w]),
            .wr(meta_wr[w])
        );

        cache_ram #(
            .DEPTH_W(l1_cache_pkg::LINE_ADDR_W),
            .WIDTH(l1_cache_pkg::DATA_W)
        ) u_data_ram (
            .clk(clk),
            .raddr(data_raddr),
            .rd(data_rd[w]),
            .waddr(data_waddr),
            .we(data_we_mux[w]),
            .wr(data_wr[w])
        );

        assign way_hit = hit && (hit_way == 1'(w));

        // Hit updates while idle, FSM enables otherwise
        assign meta_we_mux[w] = int_ready ? way_hit : meta_we[w];
        assign data_we_mux[w] = int_ready ? (way_hit && req_wen) : data_we[w];

        assign meta_wr[w] = (wb_src == l1_cache_pkg::WB_CORE) ? meta_core[w] :
                            (wb_src == l1_cache_pkg::WB_MEM)  ? meta_mem[w] : '0;

        // Byte merge of the write into the stored word
        for (genvar b = 0; b < l1_cache_pkg::STRB_W; b++) begin : g_byte
            assign merged[b*8 +: 8] = req_wmask[b] ? req_wdata[b*8 +: 8]
                                                   : data_rd[w][b*8 +: 8];
        end

        assign data_wr[w] = (wb_src == l1_cache_pkg::WB_MEM) ? mem_resp_rdata : merged;
    end

    cache_tag_check u_tag_check (
        .req_tag(req_tag),
        .req_wen(req_wen),
        .req_valid(req_valid),
        .meta_rd0(meta_rd[0]),
        .meta_rd1(meta_rd[1]),
        .hit(hit),
        .hit_way(hit_way),
        .victim(victim),
        .victim_dirty(victim_dirty),
        .victim_tag(victim_tag),
        .meta_core0(meta_core[0]),
        .meta_core1(meta_core[1]),
        .meta_mem0(meta_mem[0]),
        .meta_mem1(meta_mem[1])
    );

    cache_miss_ctrl u_miss_ctrl (
        .clk(clk),
        .rst(rst),
        .req_valid(req_valid),
        .hit(hit),
        .victim(victim),
        .victim_dirty(victim_dirty),
        .req_beat(req_beat),
        .mem_req_ready(mem_req_ready),
        .mem_resp_valid(mem_resp_valid),
        .int_ready(int_ready),
        .wb_src(wb_src),
        .meta_we(meta_we),
        .data_we(data_we),
        .reload_en(reload_en),
        .reload_beat(reload_beat),
        .clear_en(clear_en),
        .clear_set(clear_set),
        .flush_sel(flush_sel),
        .mem_req_wen(mem_req_wen),
        .mem_req_valid(mem_req_valid),
        .mem_resp_ready(mem_resp_ready)
    );

    // Line-aligned burst address, victim line for a flush
    assign mem_req_addr = {flush_sel ? victim_tag : req_tag, req_set,
                           {(l1_cache_pkg::BEAT_W + l1_cache_pkg::OFFSET_W){1'b0}}};
    assign mem_req_wdata = data_rd[victim];

    assign core_req_ready = int_ready;
    assign core_resp_valid = int_ready && hit;
    assign core_resp_rdata = int_ready ? data_rd[hit_way] : '0;

endmodule

// ==== tb/l1_cache_sva.sv ====
module l1_cache_sva (
    input logic                            clk,
    input logic                            rst,
    input logic                            core_req_ready,
    input logic [l1_cache_pkg::ADDR_W-1:0] mem_req_addr,
    input logic                            mem_req_valid,
    input logic                            mem_req_ready,
    input logic                            mem_resp_ready
);

    timeunit 1ns;
    timeprecision 1ps;

    // Core is stalled for the whole memory request phase
    a_core_stall: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid |-> !core_req_ready)
        else $error("core_req_ready high during a memory request");

    // Held request keeps its address until taken
    a_addr_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> $stable(mem_req_addr))
        else $error("mem_req_addr changed while waiting for mem_req_ready");

    // Invalidate walk leaves the response channel closed
    a_resp_idle: assert property (@(posedge clk)
        $fell(rst) |=> !mem_resp_ready)
        else $error("mem_resp_ready high right after reset");

endmodule

bind l1_cache l1_cache_sva u_sva (
    .clk(clk),
    .rst(rst),
    .core_req_ready(core_req_ready),
    .mem_req_addr(mem_req_addr),
    .mem_req_valid(mem_req_valid),
    .mem_req_ready(mem_req_ready),
    .mem_resp_ready(mem_resp_ready)
);

// ==== tb/l1_cache_tb.sv ====
module l1_cache_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_OPS = 24;
    // Tags 0 to 2 over all sets
    localparam int MEM_WORDS = 3 * l1_cache_pkg::SETS * l1_cache_pkg::BEATS;
    localparam int CYCLE_LIMIT = l1_cache_pkg::SETS + 20 + 40 * N_OPS;

    logic                            clk;
    logic                            rst;
    logic [l1_cache_pkg::ADDR_W-1:0] core_req_addr;
    logic                            core_req_wen;
    logic [l1_cache_pkg::DATA_W-1:0] core_req_wdata;
    logic [l1_cache_pkg::STRB_W-1:0] core_req_wmask;
    logic                            core_req_valid;
    logic                            core_req_ready;
    logic                            core_resp_valid;
    logic [l1_cache_pkg::DATA_W-1:0] core_resp_rdata;
    logic [l1_cache_pkg::ADDR_W-1:0] mem_req_addr;
    logic                            mem_req_wen;
    logic [l1_cache_pkg::DATA_W-1:0] mem_req_wdata;
    logic                            mem_req_valid;
    logic                            mem_req_ready;
    logic [l1_cache_pkg::DATA_W-1:0] mem_resp_rdata;
    logic                            mem_resp_valid;
    logic                            mem_resp_ready;

    // Operation table: stimulus plus the bursts each entry must cause
    logic                            op_wr [N_OPS];
    logic [l1_cache_pkg::ADDR_W-1:0] op_addr [N_OPS];
    logic [l1_cache_pkg::DATA_W-1:0] op_wdata [N_OPS];
    logic [l1_cache_pkg::STRB_W-1:0] op_wmask [N_OPS];
    logic                            op_load [N_OPS];
    logic                            op_flush [N_OPS];
    logic [l1_cache_pkg::ADDR_W-1:0] op_flush_addr [N_OPS];
    int                              n_ops;

    // Memory contents and the expected core view
    logic [l1_cache_pkg::DATA_W-1:0] mem_arr [MEM_WORDS];
    logic [l1_cache_pkg::DATA_W-1:0] shadow [MEM_WORDS];

    int                              pend_q[$];
    logic [l1_cache_pkg::DATA_W-1:0] exp_q[$];
    logic [l1_cache_pkg::ADDR_W-1:0] load_q[$];
    logic [l1_cache_pkg::ADDR_W-1:0] flush_q[$];

    int seed = 32'h7839_1382;
    int errors = 0;
    int checks = 0;
    int resp_count = 0;
    int cycle_cnt = 0;

    l1_cache uut (.*);

    function automatic logic [l1_cache_pkg::ADDR_W-1:0] line_addr(int tag, int set, int beat);
        return {l1_cache_pkg::TAG_W'(tag), l1_cache_pkg::SET_W'(set),
                l1_cache_pkg::BEAT_W'(beat), {l1_cache_pkg::OFFSET_W{1'b0}}};
    endfunction

    // Address in the upper half, its inverse below
    function automatic logic [l1_cache_pkg::DATA_W-1:0] init_word(
        logic [l1_cache_pkg::ADDR_W-1:0] addr);
        return {addr, ~addr};
    endfunction

    function automatic int word_index(logic [l1_cache_pkg::ADDR_W-1:0] addr);
        return int'(addr >> l1_cache_pkg::OFFSET_W);
    endfunction

    task automatic check_data(string name, logic [l1_cache_pkg::DATA_W-1:0] got,
                              logic [l1_cache_pkg::DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(string name, logic [l1_cache_pkg::ADDR_W-1:0] got,
                              logic [l1_cache_pkg::ADDR_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    task automatic add_op(logic wr, int tag, int set, int beat,
                          logic [l1_cache_pkg::DATA_W-1:0] wdata,
                          logic [l1_cache_pkg::STRB_W-1:0] wmask,
                          logic load, logic flush, int ftag);
        op_wr[n_ops] = wr;
        op_addr[n_ops] = line_addr(tag, set, beat);
        op_wdata[n_ops] = wdata;
        op_wmask[n_ops] = wmask;
        op_load[n_ops] = load;
        op_flush[n_ops] = flush;
        op_flush_addr[n_ops] = line_addr(ftag, set, 0);
        n_ops++;
    endtask

    task automatic fill_table();
        n_ops = 0;
        // Cold misses, hits and a masked write in set 1
        add_op(1'b0, 0, 1, 0, '0, 8'h00, 1'b1, 1'b0, 0);
        add_op(1'b0, 0, 1, 2, '0, 8'h00, 1'b0, 1'b0, 0);
        add_op(1'b1, 0, 1, 2, 64'h1122_3344_5566_7788, 8'h0f, 1'b0, 1'b0, 0);
        add_op(1'b0, 0, 1, 2, '0, 8'h00, 1'b0, 1'b0, 0);
        add_op(1'b0, 0, 2, 1, '0, 8'h00, 1'b1, 1'b0, 0);
        add_op(1'b0, 1, 1, 0, '0, 8'h00, 1'b1, 1'b0, 0);
        add_op(1'b1, 1, 1, 3, 64'hdead_beef_cafe_f00d, 8'hf0, 1'b0, 1'b0, 0);
        add_op(1'b0, 0, 1, 2, '0, 8'h00, 1'b0, 1'b0, 0);
        // Third tag in set 1 evicts dirty tag 1
        add_op(1'b0, 2, 1, 0, '0, 8'h00, 1'b1, 1'b1, 1);
        add_op(1'b0, 0, 1, 2, '0, 8'h00, 1'b0, 1'b0, 0);
        add_op(1'b0, 1, 1, 3, '0, 8'h00, 1'b1, 1'b0, 0);
        add_op(1'b0, 1, 1, 0, '0, 8'h00, 1'b0, 1'b0, 0);
        // Back-to-back hits over different lines
        add_op(1'b0, 0, 2, 1, '0, 8'h00, 1'b0, 1'b0, 0);
        add_op(1'b0, 0, 1, 1, '0, 8'h00, 1'b0, 1'b0, 0);
        add_op(1'b0, 1, 1, 2, '0, 8'h00, 1'b0, 1'b0, 0);
        add_op(1'b0, 0, 2, 3, '0, 8'h00, 1'b0, 1'b0, 0);
        // Write misses and two flushes in set 5
        add_op(1'b1, 2, 5, 0, 64'h0123_4567_89ab_cdef, 8'hff, 1'b1, 1'b0, 0);
        add_op(1'b0, 2, 5, 0, '0, 8'h00, 1'b0, 1'b0, 0);
        add_op(1'b1, 0, 5, 1, 64'haa55_aa55_aa55_aa55, 8'h81, 1'b1, 1'b0, 0);
        add_op(1'b0, 1, 5, 2, '0, 8'h00, 1'b1, 1'b1, 2);
        add_op(1'b0, 2, 5, 0, '0, 8'h00, 1'b1, 1'b1, 0);
        add_op(1'b0, 0, 5, 1, '0, 8'h00, 1'b1, 1'b0, 0);
        add_op(1'b0, 0, 15, 3, '0, 8'h00, 1'b1, 1'b0, 0);
        add_op(1'b0, 0, 15, 3, '0, 8'h00, 1'b0, 1'b0, 0);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        errors++;
        $display("Run timed out after %0d cycles with %0d of %0d responses",
                 cycle_cnt, resp_count, N_OPS);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Finished with errors");
        $finish;
    end

    // Burst memory with random handshake delays
    initial begin : memory_model
        int                              delay;
        int                              idx;
        logic [l1_cache_pkg::ADDR_W-1:0] base;
        mem_req_ready = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_rdata = '0;
        forever begin
            @(negedge clk);
            if (mem_req_valid) begin
                base = mem_req_addr;
                idx = word_index(base);
                if (idx + l1_cache_pkg::BEATS > MEM_WORDS) begin
                    errors++;
                    $display("Memory burst to address %h lies outside the model", base);
                    idx = 0;
                end
                if (mem_req_wen) begin
                    for (int k = 0; k < l1_cache_pkg::BEATS; k++) begin
                        while (!mem_req_valid) @(negedge clk);
                        delay = $unsigned($random(seed)) % 4;
                        repeat (delay) @(negedge clk);
                        mem_req_ready = 1'b1;
                        check_addr("mem_req_addr", mem_req_addr, base);
                        // Victim data must match every write made so far
                        check_data("mem_req_wdata", mem_req_wdata, shadow[idx + k]);
                        mem_arr[idx + k] = mem_req_wdata;
                        @(negedge clk);
                        mem_req_ready = 1'b0;
                    end
                    flush_q.push_back(base);
                    delay = $unsigned($random(seed)) % 4;
                    repeat (delay) @(negedge clk);
                    // Write acknowledge
                    mem_resp_valid = 1'b1;
                    while (!mem_resp_ready) @(negedge clk);
                    @(negedge clk);
                    mem_resp_valid = 1'b0;
                end else begin
                    delay = $unsigned($random(seed)) % 4;
                    repeat (delay) @(negedge clk);
                    mem_req_ready = 1'b1;
                    @(negedge clk);
                    mem_req_ready = 1'b0;
                    load_q.push_back(base);
                    for (int k = 0; k < l1_cache_pkg::BEATS; k++) begin
                        delay = $unsigned($random(seed)) % 4;
                        repeat (delay) @(negedge clk);
                        mem_resp_valid = 1'b1;
                        mem_resp_rdata = mem_arr[idx + k];
                        // Beat stays offered until the cache takes it
                        while (!mem_resp_ready) @(negedge clk);
                        @(negedge clk);
                        mem_resp_valid = 1'b0;
                    end
                end
            end
        end
    end

    // Responses come back in request order
    always @(negedge clk) begin
        int                              i;
        logic [l1_cache_pkg::DATA_W-1:0] exp;
        if (core_resp_valid) begin
            if (pend_q.size() == 0) begin
                errors++;
                $display("Core response arrived with no request outstanding");
            end else begin
                i = pend_q.pop_front();
                exp = exp_q.pop_front();
                resp_count++;
                if (!op_wr[i]) begin
                    check_data($sformatf("core_resp_rdata[%0d]", i), core_resp_rdata, exp);
                end
                if (op_flush[i]) begin
                    if (flush_q.size() == 0) begin
                        errors++;
                        $display("Entry %0d completed without its write burst", i);
                    end else begin
                        check_addr("flush mem_req_addr", flush_q.pop_front(), op_flush_addr[i]);
                    end
                end
                if (op_load[i]) begin
                    if (load_q.size() == 0) begin
                        errors++;
                        $display("Entry %0d completed without its read burst", i);
                    end else begin
                        check_addr("load mem_req_addr", load_q.pop_front(),
                                   op_addr[i] & ~l1_cache_pkg::ADDR_W'(8'h1f));
                    end
                end
                if (load_q.size() != 0 || flush_q.size() != 0) begin
                    errors++;
                    $display("Entry %0d caused a memory burst that was not expected", i);
                    load_q.delete();
                    flush_q.delete();
                end
            end
        end
    end

    initial begin
        int idx;
        for (int w = 0; w < MEM_WORDS; w++) begin
            mem_arr[w] = init_word(l1_cache_pkg::ADDR_W'(w * l1_cache_pkg::STRB_W));
            shadow[w] = mem_arr[w];
        end
        fill_table();
        rst = 1'b1;
        core_req_addr = '0;
        core_req_wen = 1'b0;
        core_req_wdata = '0;
        core_req_wmask = '0;
        core_req_valid = 1'b0;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < N_OPS; i++) begin
            core_req_valid = 1'b1;
            core_req_addr = op_addr[i];
            core_req_wen = op_wr[i];
            core_req_wdata = op_wdata[i];
            core_req_wmask = op_wmask[i];
            while (!core_req_ready) @(negedge clk);
            // Taken on the coming rising edge
            idx = word_index(op_addr[i]);
            pend_q.push_back(i);
            exp_q.push_back(shadow[idx]);
            if (op_wr[i]) begin
                for (int b = 0; b < l1_cache_pkg::STRB_W; b++) begin
                    if (op_wmask[i][b]) begin
                        shadow[idx][b*8 +: 8] = op_wdata[i][b*8 +: 8];
                    end
                end
            end
            @(negedge clk);
        end
        core_req_valid = 1'b0;
        core_req_wen = 1'b0;

        while (resp_count < N_OPS) @(negedge clk);
        repeat (4) @(negedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
hdl/l1_cache_pkg.sv
hdl/cache_ram.sv
hdl/cache_tag_check.sv
hdl/cache_miss_ctrl.sv
hdl/l1_cache.sv
tb/l1_cache_sva.sv
tb/l1_cache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module l1_cache_tb -Mdir obj_dir \
    || { echo "Build failed"; exit 1; }

out="$(./obj_dir/Vl1_cache_tb)"
echo "$out"
grep -qx "Finished with no errors" <<< "$out" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
